//--- source/tensor_pkg.sv
package tensor_pkg;

    // element width, integer lanes with wrap on overflow
    localparam int ELEM_W = 32;

    // tile shape m x k x n
    localparam int TILE_M = 4;
    localparam int TILE_K = 2;
    localparam int TILE_N = 4;

    // split of D rows across threadgroups
    localparam int GROUP_ROWS = 2;
    localparam int NUM_GROUPS = 2;

    // warp id carried next to each tile
    localparam int WID_W = 4;

    // stages in one dot-product unit
    localparam int LATENCY_DPU = 2;

    // entries in the output queue
    localparam int RESULT_DEPTH = 2;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [WID_W-1:0]  wid_t;

    // row-major, first index is the row
    typedef elem_t [TILE_M-1:0][TILE_K-1:0] a_tile_t;
    typedef elem_t [TILE_K-1:0][TILE_N-1:0] b_tile_t;

    // used for both C and D
    typedef elem_t [TILE_M-1:0][TILE_N-1:0] c_tile_t;

    // everything the pipeline needs for one tile
    typedef struct packed {
        a_tile_t a;
        b_tile_t b;
        c_tile_t c;
    } operand_t;

endpackage

//--- source/tile_if.sv
`timescale 1ns/1ns

// valid/ready link between the three parts of the core
// transfer on any rising edge with valid and ready both high
interface tile_if #(
    parameter type payload_t = tensor_pkg::c_tile_t
);

    logic             valid;
    logic             ready;
    payload_t         payload;
    tensor_pkg::wid_t wid;

    // producer side
    // valid, payload and wid held steady until taken
    modport source (
        output valid,
        output payload,
        output wid,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  payload,
        input  wid,
        output ready
    );

endinterface

//--- source/dot_product_unit.sv
`timescale 1ns/1ns

// computes a0*b0 + a1*b1 + c over two stages
module dot_product_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    input  logic              stall,
    input  tensor_pkg::elem_t a0,
    input  tensor_pkg::elem_t a1,
    input  tensor_pkg::elem_t b0,
    input  tensor_pkg::elem_t b1,
    input  tensor_pkg::elem_t c,
    output logic              valid_out,
    output tensor_pkg::elem_t result
);

    // stage 1 registers
    logic              s1_valid;
    tensor_pkg::elem_t prod0;
    tensor_pkg::elem_t prod1;
    tensor_pkg::elem_t addend;

    // valid bits, frozen with the data
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            valid_out <= 1'b0;
        end else if (!stall) begin
            s1_valid  <= valid_in;
            valid_out <= s1_valid;
        end
    end

    // products keep low 32 bits only
    always_ff @(posedge clk) begin
        if (!stall) begin
            prod0  <= a0 * b0;
            prod1  <= a1 * b1;
            addend <= c;
        end
    end

    // stage 2, three-way sum with wrap
    always_ff @(posedge clk) begin
        if (!stall) begin
            result <= prod0 + prod1 + addend;
        end
    end

endmodule

//--- source/tensor_threadgroup.sv
`timescale 1ns/1ns

// two rows of D, one unit per output element
module tensor_threadgroup (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid_in,
    input  logic                stall,
    input  tensor_pkg::elem_t [tensor_pkg::GROUP_ROWS-1:0][tensor_pkg::TILE_K-1:0] a_frag,
    input  tensor_pkg::b_tile_t b_frag,
    input  tensor_pkg::elem_t [tensor_pkg::GROUP_ROWS-1:0][tensor_pkg::TILE_N-1:0] c_frag,
    output logic                valid_out,
    output tensor_pkg::elem_t [tensor_pkg::GROUP_ROWS-1:0][tensor_pkg::TILE_N-1:0] d_frag
);

    logic [tensor_pkg::GROUP_ROWS-1:0][tensor_pkg::TILE_N-1:0] valids;

    // row r of A against column n of B
    for (genvar r = 0; r < tensor_pkg::GROUP_ROWS; r++) begin : g_row
        for (genvar n = 0; n < tensor_pkg::TILE_N; n++) begin : g_col
            dot_product_unit u_dp (
                .clk       (clk),
                .reset     (reset),
                .valid_in  (valid_in),
                .stall     (stall),
                .a0        (a_frag[r][0]),
                .a1        (a_frag[r][1]),
                .b0        (b_frag[0][n]),
                .b1        (b_frag[1][n]),
                .c         (c_frag[r][n]),
                .valid_out (valids[r][n]),
                .result    (d_frag[r][n])
            );
        end
    end

    assign valid_out = &valids;

    // units share valid_in and stall, so they move in lockstep
    assert property (@(posedge clk) disable iff (reset)
        (&valids) || !(|valids));

endmodule

//--- source/tile_receiver.sv
`timescale 1ns/1ns

module tile_receiver (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_req,
    input  tensor_pkg::a_tile_t a_tile,
    input  tensor_pkg::b_tile_t b_tile,
    input  tensor_pkg::c_tile_t c_tile,
    input  tensor_pkg::wid_t    in_wid,
    output logic                in_ack,
    tile_if.source              op
);

    typedef enum logic {
        WAIT_REQ,
        WAIT_DROP
    } rx_state_t;

    rx_state_t state;
    logic      holder_free;
    logic      capture;

    // holder counts as free when the pipeline takes it this cycle
    assign holder_free = !op.valid || op.ready;
    assign capture     = (state == WAIT_REQ) && in_req && holder_free;

    // ack is the handshake state itself
    assign in_ack = (state == WAIT_DROP);

    // four-phase slave
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WAIT_REQ;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (capture) begin
                        state <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    // master has let go, release ack
                    if (!in_req) begin
                        state <= WAIT_REQ;
                    end
                end
                default: state <= WAIT_REQ;
            endcase
        end
    end

    // holding flag, offered on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (reset) begin
            op.valid <= 1'b0;
        end else if (capture) begin
            op.valid <= 1'b1;
        end else if (op.ready) begin
            op.valid <= 1'b0;
        end
    end

    // operand holder, payload only
    always_ff @(posedge clk) begin
        if (capture) begin
            op.payload <= tensor_pkg::operand_t'{a_tile, b_tile, c_tile};
            op.wid     <= in_wid;
        end
    end

    // offered tile must not move under a stalled sink
    assert property (@(posedge clk) disable iff (reset)
        op.valid && !op.ready |=> $stable(op.payload) && $stable(op.wid));

endmodule

//--- source/tensor_dpu.sv
`timescale 1ns/1ns

module tensor_dpu (
    input  logic   clk,
    input  logic   reset,
    tile_if.sink   op,
    tile_if.source res
);

    logic                                 stall;
    logic                                 fire;
    logic [tensor_pkg::NUM_GROUPS-1:0]    group_valid;
    logic [tensor_pkg::LATENCY_DPU-1:0]   vld_pipe;
    tensor_pkg::wid_t                     wid_pipe [tensor_pkg::LATENCY_DPU];

    // per-group slice of D
    tensor_pkg::elem_t [tensor_pkg::GROUP_ROWS-1:0][tensor_pkg::TILE_N-1:0]
        d_frag [tensor_pkg::NUM_GROUPS];

    // whole pipeline freezes with the sink
    assign stall    = !res.ready;
    assign op.ready = res.ready;
    assign fire     = op.valid && op.ready;

    // A and C split by row pairs, B shared
    for (genvar g = 0; g < tensor_pkg::NUM_GROUPS; g++) begin : g_group
        tensor_threadgroup u_tg (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (fire),
            .stall     (stall),
            .a_frag    (op.payload.a[g*tensor_pkg::GROUP_ROWS +: tensor_pkg::GROUP_ROWS]),
            .b_frag    (op.payload.b),
            .c_frag    (op.payload.c[g*tensor_pkg::GROUP_ROWS +: tensor_pkg::GROUP_ROWS]),
            .valid_out (group_valid[g]),
            .d_frag    (d_frag[g])
        );
    end

    // reassemble D from the group slices
    always_comb begin
        for (int g = 0; g < tensor_pkg::NUM_GROUPS; g++) begin
            res.payload[g*tensor_pkg::GROUP_ROWS +: tensor_pkg::GROUP_ROWS] = d_frag[g];
        end
    end

    // metadata delay line, same depth as the units
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else if (!stall) begin
            vld_pipe[0] <= fire;
            for (int i = 1; i < tensor_pkg::LATENCY_DPU; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // wid needs no reset, qualified by vld_pipe
    always_ff @(posedge clk) begin
        if (!stall) begin
            wid_pipe[0] <= op.wid;
            for (int i = 1; i < tensor_pkg::LATENCY_DPU; i++) begin
                wid_pipe[i] <= wid_pipe[i-1];
            end
        end
    end

    assign res.valid = vld_pipe[tensor_pkg::LATENCY_DPU-1];
    assign res.wid   = wid_pipe[tensor_pkg::LATENCY_DPU-1];

    // both groups track the metadata line
    assert property (@(posedge clk) disable iff (reset)
        group_valid == {tensor_pkg::NUM_GROUPS{res.valid}});

endmodule

//--- source/result_sender.sv
`timescale 1ns/1ns

module result_sender (
    input  logic                clk,
    input  logic                reset,
    tile_if.sink                res,
    output logic                out_req,
    output tensor_pkg::c_tile_t d_tile,
    output tensor_pkg::wid_t    out_wid,
    input  logic                out_ack
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_WAIT_LOW
    } tx_state_t;

    tx_state_t state;

    // circular queue storage
    tensor_pkg::c_tile_t q_data [tensor_pkg::RESULT_DEPTH];
    tensor_pkg::wid_t    q_wid  [tensor_pkg::RESULT_DEPTH];

    logic [$clog2(tensor_pkg::RESULT_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(tensor_pkg::RESULT_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(tensor_pkg::RESULT_DEPTH+1)-1:0] count;
    logic                                          push;
    logic                                          pop;

    assign res.ready = (count != tensor_pkg::RESULT_DEPTH);
    assign push      = res.valid && res.ready;
    // entry leaves when req drops on a seen ack
    assign pop       = (state == TX_REQ) && out_ack;

    // head entry always on the ports
    assign d_tile  = q_data[rd_ptr];
    assign out_wid = q_wid[rd_ptr];
    assign out_req = (state == TX_REQ);

    always_ff @(posedge clk) begin
        if (push) begin
            q_data[wr_ptr] <= res.payload;
            q_wid[wr_ptr]  <= res.wid;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == tensor_pkg::RESULT_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == tensor_pkg::RESULT_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // four-phase master
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE:     if (count != 0) state <= TX_REQ;
                TX_REQ:      if (out_ack) state <= TX_WAIT_LOW;
                // next req only once ack seen low
                TX_WAIT_LOW: if (!out_ack) state <= TX_IDLE;
                default:     state <= TX_IDLE;
            endcase
        end
    end

    // full queue means pointers have met, never beyond depth
    assert property (@(posedge clk) disable iff (reset)
        (count <= tensor_pkg::RESULT_DEPTH) &&
        ((count == tensor_pkg::RESULT_DEPTH) -> (wr_ptr == rd_ptr)));

    // req held until the responder has acked
    assert property (@(posedge clk) disable iff (reset)
        $fell(out_req) |-> $past(out_ack));

endmodule

//--- source/tensor_core_top.sv
`timescale 1ns/1ns

module tensor_core_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_req,
    output logic                in_ack,
    input  tensor_pkg::a_tile_t a_tile,
    input  tensor_pkg::b_tile_t b_tile,
    input  tensor_pkg::c_tile_t c_tile,
    input  tensor_pkg::wid_t    in_wid,
    output logic                out_req,
    input  logic                out_ack,
    output tensor_pkg::c_tile_t d_tile,
    output tensor_pkg::wid_t    out_wid
);

    // operands into the pipeline
    tile_if #(.payload_t(tensor_pkg::operand_t)) op_link ();
    // finished D tiles out of it
    tile_if #(.payload_t(tensor_pkg::c_tile_t)) res_link ();

    tile_receiver u_receiver (
        .clk    (clk),
        .reset  (reset),
        .in_req (in_req),
        .a_tile (a_tile),
        .b_tile (b_tile),
        .c_tile (c_tile),
        .in_wid (in_wid),
        .in_ack (in_ack),
        .op     (op_link.source)
    );

    tensor_dpu u_dpu (
        .clk   (clk),
        .reset (reset),
        .op    (op_link.sink),
        .res   (res_link.source)
    );

    result_sender u_sender (
        .clk     (clk),
        .reset   (reset),
        .res     (res_link.sink),
        .out_req (out_req),
        .d_tile  (d_tile),
        .out_wid (out_wid),
        .out_ack (out_ack)
    );

endmodule

//--- tests/tensor_core_tb.sv
`timescale 1ns/1ns

module tensor_core_tb;

    localparam int CLK_PERIOD      = 8;
    // single, random, back-pressure, corner, cut by reset, after reset
    localparam int TOTAL_TILES     = 1 + 60 + 40 + 4 + 2 + 8;
    localparam int CYCLES_PER_TILE = 40;
    localparam int D_W             = $bits(tensor_pkg::c_tile_t);

    logic                clk;
    logic                reset;
    logic                in_req;
    logic                in_ack;
    tensor_pkg::a_tile_t a_tile;
    tensor_pkg::b_tile_t b_tile;
    tensor_pkg::c_tile_t c_tile;
    tensor_pkg::wid_t    in_wid;
    logic                out_req;
    logic                out_ack;
    tensor_pkg::c_tile_t d_tile;
    tensor_pkg::wid_t    out_wid;

    integer seed;
    int     max_delay;
    logic   hold_ack;
    int     errors;
    int     start_errors;
    int     tests_run;

    // expected results in send order
    tensor_pkg::c_tile_t exp_d [$];
    tensor_pkg::wid_t    exp_wid [$];

    // values at the edges of signed and unsigned range
    tensor_pkg::elem_t corner_vals [5] = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF,
                                           32'hFFFF_FFFE, 32'h0000_0001};

    tensor_core_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .a_tile  (a_tile),
        .b_tile  (b_tile),
        .c_tile  (c_tile),
        .in_wid  (in_wid),
        .out_req (out_req),
        .out_ack (out_ack),
        .d_tile  (d_tile),
        .out_wid (out_wid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // D = A*B + C with every element wrapped to 32 bits
    function automatic tensor_pkg::c_tile_t ref_matmul(input tensor_pkg::a_tile_t a,
                                                       input tensor_pkg::b_tile_t b,
                                                       input tensor_pkg::c_tile_t c);
        tensor_pkg::c_tile_t d;
        tensor_pkg::elem_t   acc;
        for (int m = 0; m < tensor_pkg::TILE_M; m++) begin
            for (int n = 0; n < tensor_pkg::TILE_N; n++) begin
                acc = c[m][n];
                for (int k = 0; k < tensor_pkg::TILE_K; k++) begin
                    acc = acc + a[m][k] * b[k][n];
                end
                d[m][n] = acc;
            end
        end
        return d;
    endfunction

    task automatic check_value(input string name, input logic [D_W-1:0] expected,
                               input logic [D_W-1:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // four-phase master on the input side
    // inputs change 1 ns after the edge
    task automatic send_tile(input tensor_pkg::a_tile_t a, input tensor_pkg::b_tile_t b,
                             input tensor_pkg::c_tile_t c, input tensor_pkg::wid_t wid);
        @(posedge clk);
        #1;
        a_tile = a;
        b_tile = b;
        c_tile = c;
        in_wid = wid;
        exp_d.push_back(ref_matmul(a, b, c));
        exp_wid.push_back(wid);
        in_req = 1'b1;
        // held off while the pipeline is stalled
        while (!in_ack) begin
            @(posedge clk);
            #1;
        end
        in_req = 1'b0;
        while (in_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic random_tile(input tensor_pkg::wid_t wid);
        tensor_pkg::a_tile_t a;
        tensor_pkg::b_tile_t b;
        tensor_pkg::c_tile_t c;
        for (int i = 0; i < tensor_pkg::TILE_M * tensor_pkg::TILE_K; i++) begin
            a[i / tensor_pkg::TILE_K][i % tensor_pkg::TILE_K] = $random(seed);
        end
        for (int i = 0; i < tensor_pkg::TILE_K * tensor_pkg::TILE_N; i++) begin
            b[i / tensor_pkg::TILE_N][i % tensor_pkg::TILE_N] = $random(seed);
        end
        for (int i = 0; i < tensor_pkg::TILE_M * tensor_pkg::TILE_N; i++) begin
            c[i / tensor_pkg::TILE_N][i % tensor_pkg::TILE_N] = $random(seed);
        end
        send_tile(a, b, c, wid);
    endtask

    // every element drawn from the corner set
    task automatic corner_tile(input tensor_pkg::wid_t wid);
        tensor_pkg::a_tile_t a;
        tensor_pkg::b_tile_t b;
        tensor_pkg::c_tile_t c;
        for (int i = 0; i < tensor_pkg::TILE_M * tensor_pkg::TILE_K; i++) begin
            a[i / 2][i % 2] = corner_vals[$unsigned($random(seed)) % 5];
        end
        for (int i = 0; i < tensor_pkg::TILE_K * tensor_pkg::TILE_N; i++) begin
            b[i / 4][i % 4] = corner_vals[$unsigned($random(seed)) % 5];
        end
        for (int i = 0; i < tensor_pkg::TILE_M * tensor_pkg::TILE_N; i++) begin
            c[i / 4][i % 4] = corner_vals[$unsigned($random(seed)) % 5];
        end
        send_tile(a, b, c, wid);
    endtask

    // until every sent tile is back and both handshakes are idle
    task automatic wait_drain();
        while (exp_d.size() != 0 || out_req || out_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        wait_drain();
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
        start_errors = errors;
    endtask

    // output responder acks within max_delay cycles
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack && !hold_ack) begin
                delay = (max_delay > 0) ? $unsigned($random(seed)) % (max_delay + 1) : 0;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
            end else if (!out_req && out_ack) begin
                out_ack = 1'b0;
            end
        end
    end

    // compare on each ack rise while the head entry sits on the ports
    initial begin
        forever begin
            @(posedge out_ack);
            if (exp_d.size() == 0) begin
                $display("result returned with no tile outstanding");
                errors++;
            end else begin
                check_value("d_tile", exp_d.pop_front(), d_tile);
                check_value("out_wid", exp_wid.pop_front(), out_wid);
            end
        end
    end

    // watchdog allows 40 cycles per tile
    initial begin
        #(TOTAL_TILES * CYCLES_PER_TILE * CLK_PERIOD);
        $display("run timed out before all tiles came back");
        $display("Errors found");
        $finish;
    end

    initial begin
        tensor_pkg::a_tile_t a;
        tensor_pkg::b_tile_t b;
        tensor_pkg::c_tile_t c;
        seed         = 32'h106d;
        max_delay    = 0;
        hold_ack     = 1'b0;
        errors       = 0;
        start_errors = 0;
        tests_run    = 0;
        reset        = 1'b1;
        in_req       = 1'b0;
        out_ack      = 1'b0;
        a_tile       = '0;
        b_tile       = '0;
        c_tile       = '0;
        in_wid       = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // A all ones and B counting up with C holding the row index
        for (int m = 0; m < tensor_pkg::TILE_M; m++) begin
            for (int n = 0; n < tensor_pkg::TILE_N; n++) begin
                c[m][n] = m;
            end
            for (int k = 0; k < tensor_pkg::TILE_K; k++) begin
                a[m][k] = 1;
            end
        end
        for (int k = 0; k < tensor_pkg::TILE_K; k++) begin
            for (int n = 0; n < tensor_pkg::TILE_N; n++) begin
                b[k][n] = k * tensor_pkg::TILE_N + n + 1;
            end
        end
        send_tile(a, b, c, 4'h5);
        finish_test("single tile");

        for (int i = 0; i < 60; i++) begin
            random_tile(tensor_pkg::wid_t'($random(seed)));
        end
        finish_test("random tiles, immediate ack");

        // slow ack fills the queue and stalls the pipeline
        max_delay = 15;
        for (int i = 0; i < 40; i++) begin
            random_tile(tensor_pkg::wid_t'($random(seed)));
        end
        finish_test("random tiles, delayed ack");
        max_delay = 0;

        // all ones and all MSB first then mixed corners
        a = {tensor_pkg::TILE_M * tensor_pkg::TILE_K{32'hFFFF_FFFF}};
        b = {tensor_pkg::TILE_K * tensor_pkg::TILE_N{32'hFFFF_FFFF}};
        c = {tensor_pkg::TILE_M * tensor_pkg::TILE_N{32'hFFFF_FFFF}};
        send_tile(a, b, c, 4'hF);
        a = {tensor_pkg::TILE_M * tensor_pkg::TILE_K{32'h8000_0000}};
        b = {tensor_pkg::TILE_K * tensor_pkg::TILE_N{32'h8000_0000}};
        c = {tensor_pkg::TILE_M * tensor_pkg::TILE_N{32'h8000_0000}};
        send_tile(a, b, c, 4'h8);
        corner_tile(4'h1);
        corner_tile(4'h2);
        finish_test("wrap at 32 bits");

        // a result left on out_req and a second request left acked
        hold_ack = 1'b1;
        random_tile(tensor_pkg::wid_t'($random(seed)));
        while (!out_req) begin
            @(posedge clk);
            #1;
        end
        in_req = 1'b1;
        while (!in_ack) begin
            @(posedge clk);
            #1;
        end
        // req still high through reset so a stuck ack would show
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("in_ack", 1'b0, in_ack);
        check_value("out_req", 1'b0, out_req);
        in_req   = 1'b0;
        hold_ack = 1'b0;
        // tile cut off by reset never comes back
        exp_d.delete();
        exp_wid.delete();
        for (int i = 0; i < 8; i++) begin
            random_tile(tensor_pkg::wid_t'($random(seed)));
        end
        finish_test("tiles after reset");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/tensor_pkg.sv
source/tile_if.sv
source/dot_product_unit.sv
source/tensor_threadgroup.sv
source/tile_receiver.sv
source/tensor_dpu.sv
source/result_sender.sv
source/tensor_core_top.sv
tests/tensor_core_tb.sv

//--- Bender.yml
package:
  name: tensor_core

sources:
  - files:
      - source/tensor_pkg.sv
      - source/tile_if.sv
      - source/dot_product_unit.sv
      - source/tensor_threadgroup.sv
      - source/tile_receiver.sv
      - source/tensor_dpu.sv
      - source/result_sender.sv
      - source/tensor_core_top.sv
  - target: test
    files:
      - tests/tensor_core_tb.sv
